/* creg_subsystem.f */
verilog/creg_pkg.sv
verilog/apb_creg_bridge.sv
verilog/trap_sequencer.sv
verilog/control_registers.sv
verilog/creg_subsystem.sv
verif/tb_clock.sv
verif/creg_tb.sv

/* Makefile */
# Verilator lint and simulation of the control register subsystem

TOP = creg_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f creg_subsystem.f

# The testbench ends every failing run with $fatal, so the exit status carries the result
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f creg_subsystem.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* verif/creg_tb.sv */
// Testbench top for the control register subsystem
// LFSR stimulus, reference model of the register state, checks and watchdog

`timescale 1ns/10ps

module creg_tb
    import creg_pkg::*;
    ();

    localparam NUM_THREADS = 4;
    localparam CORE_ID = 1;
    localparam RANDOM_OPS = 300;
    localparam DIRECTED_TRANSFERS = 250;

    // One level of saved trap state
    typedef struct packed {
        logic [2:0] flags;
        logic [3:0] reason;
        scalar_t pc;
        scalar_t addr;
        logic [3:0] sub;
        scalar_t scr0;
        scalar_t scr1;
    } level_t;

    logic clk;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [11:0] paddr;
    scalar_t pwdata;
    scalar_t prdata;
    logic pready;
    logic pslverr;
    logic trap_valid;
    trap_reason_t trap_reason;
    scalar_t trap_pc;
    scalar_t trap_access_addr;
    logic [1:0] trap_thread;
    subcycle_t trap_subcycle;
    logic eret_valid;
    logic [1:0] eret_thread;
    logic eret_ready;
    logic [NUM_THREADS - 1:0] mmu_en;
    logic [NUM_THREADS - 1:0] supervisor_en;
    logic [NUM_THREADS - 1:0] interrupt_en;
    logic [ASID_WIDTH - 1:0] current_asid[NUM_THREADS];
    scalar_t eret_address[NUM_THREADS];
    scalar_t trap_handler;
    scalar_t tlb_miss_handler;

    // Reference model, flags are {supervisor, mmu, interrupt}
    logic [2:0] model_flags[NUM_THREADS];
    logic [7:0] model_asid[NUM_THREADS];
    level_t saved[2][NUM_THREADS];
    scalar_t model_handler;
    scalar_t model_tlb_handler;
    scalar_t lfsr_state;

    tb_clock clock_gen(.clk, .reset);

    creg_subsystem #(.NUM_THREADS(NUM_THREADS), .CORE_ID(CORE_ID)) uut(.*);

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic scalar_t take_bits(input int count);
        scalar_t value;
        logic feedback;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [11:0] reg_addr(input int t, input int idx);
        return 12'((t << THREAD_INDEX_LSB) | (idx << REG_INDEX_LSB));
    endfunction

    task automatic check_value(input string name, input scalar_t got, input scalar_t exp);
        assert (got == exp)
        else
        begin
            $display("Fail %s expected %h got %h", name, exp, got);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic model_reset();
        for (int t = 0; t < NUM_THREADS; t++)
        begin
            model_flags[t] = 3'b100;
            model_asid[t] = '0;
            saved[0][t] = '0;
            saved[1][t] = '0;
        end
        model_handler = '0;
        model_tlb_handler = '0;
    endtask

    task automatic model_write(input int t, input int idx, input scalar_t val);
        case (5'(idx))
            CR_FLAGS:            model_flags[t] = val[2:0];
            CR_SAVED_FLAGS:      saved[0][t].flags = val[2:0];
            CR_TRAP_PC:          saved[0][t].pc = val;
            CR_TRAP_HANDLER:     model_handler = val;
            CR_TLB_MISS_HANDLER: model_tlb_handler = val;
            CR_SCRATCHPAD0:      saved[0][t].scr0 = val;
            CR_SCRATCHPAD1:      saved[0][t].scr1 = val;
            CR_SUBCYCLE:         saved[0][t].sub = val[3:0];
            CR_CURRENT_ASID:     model_asid[t] = val[7:0];
            default:
                ;
        endcase
    endtask

    task automatic model_trap(input int t, input int reason, input scalar_t pc,
        input scalar_t addr, input int sub);
        saved[1][t] = saved[0][t];
        saved[0][t].flags = model_flags[t];
        saved[0][t].reason = 4'(reason);
        saved[0][t].pc = pc;
        saved[0][t].addr = addr;
        saved[0][t].sub = 4'(sub);
        // Handler runs in supervisor mode with interrupts masked
        model_flags[t][0] = 1'b0;
        model_flags[t][2] = 1'b1;
        if (reason == TR_ITLB_MISS || reason == TR_DTLB_MISS)
            model_flags[t][1] = 1'b0;
    endtask

    task automatic model_eret(input int t);
        model_flags[t] = saved[0][t].flags;
        saved[0][t] = saved[1][t];
    endtask

    function automatic scalar_t expected_read(input int t, input int idx);
        case (5'(idx))
            CR_FLAGS:            return scalar_t'(model_flags[t]);
            CR_SAVED_FLAGS:      return scalar_t'(saved[0][t].flags);
            CR_THREAD_ID:        return scalar_t'(CORE_ID * NUM_THREADS + t);
            CR_TRAP_PC:          return saved[0][t].pc;
            CR_TRAP_REASON:      return scalar_t'(saved[0][t].reason);
            CR_TRAP_HANDLER:     return model_handler;
            CR_TRAP_ADDRESS:     return saved[0][t].addr;
            CR_TLB_MISS_HANDLER: return model_tlb_handler;
            CR_SCRATCHPAD0:      return saved[0][t].scr0;
            CR_SCRATCHPAD1:      return saved[0][t].scr1;
            CR_SUBCYCLE:         return scalar_t'(saved[0][t].sub);
            CR_CURRENT_ASID:     return scalar_t'(model_asid[t]);
            default:             return 32'hffffffff;
        endcase
    endfunction

    task automatic check_outputs();
        for (int t = 0; t < NUM_THREADS; t++)
        begin
            check_value($sformatf("supervisor_en[%0d]", t), scalar_t'(supervisor_en[t]),
                scalar_t'(model_flags[t][2]));
            check_value($sformatf("mmu_en[%0d]", t), scalar_t'(mmu_en[t]),
                scalar_t'(model_flags[t][1]));
            check_value($sformatf("interrupt_en[%0d]", t), scalar_t'(interrupt_en[t]),
                scalar_t'(model_flags[t][0]));
            check_value($sformatf("current_asid[%0d]", t), scalar_t'(current_asid[t]),
                scalar_t'(model_asid[t]));
            check_value($sformatf("eret_address[%0d]", t), eret_address[t], saved[0][t].pc);
        end
        check_value("trap_handler", trap_handler, model_handler);
        check_value("tlb_miss_handler", tlb_miss_handler, model_tlb_handler);
    endtask

    // Setup cycle, access cycle, then wait out the wait state
    task automatic apb_transfer(input logic write, input logic [11:0] addr, input scalar_t wdata,
        output scalar_t rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= write;
        paddr <= addr;
        pwdata <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready)
        begin
            waited++;
            assert (waited < 8)
            else
            begin
                $display("APB slave never raised pready");
                $display("TESTS FAILED");
                $fatal(1);
            end
            @(negedge clk);
        end
        // Exactly one wait state
        check_value("pready wait cycles", scalar_t'(waited), 32'h1);
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic reg_write(input int t, input int idx, input scalar_t val);
        scalar_t rdata;
        logic err;
        apb_transfer(1'b1, reg_addr(t, idx), val, rdata, err);
        check_value("pslverr", scalar_t'(err), '0);
        model_write(t, idx, val);
        check_outputs();
    endtask

    task automatic read_check(input int t, input int idx);
        scalar_t rdata;
        logic err;
        apb_transfer(1'b0, reg_addr(t, idx), '0, rdata, err);
        check_value("pslverr", scalar_t'(err), '0);
        // Cycle count has its own check
        if (idx != CR_CYCLE_COUNT)
            check_value($sformatf("prdata t%0d r%0d", t, idx), rdata, expected_read(t, idx));
    endtask

    task automatic read_thread_all(input int t);
        for (int i = 0; i <= CR_CURRENT_ASID; i++)
            read_check(t, i);
    endtask

    // Nonzero bits either above the thread field or in the byte offset
    task automatic bad_access(input logic write, input int t, input int idx, input scalar_t data,
        input logic upper);
        logic [11:0] addr;
        scalar_t rdata;
        logic err;
        if (upper)
            addr = reg_addr(t, idx) | {3'(take_bits(2) + 1), 9'b0};
        else
            addr = reg_addr(t, idx) | 12'(take_bits(1) + 1);
        apb_transfer(write, addr, data, rdata, err);
        check_value("pslverr", scalar_t'(err), 32'h1);
        check_outputs();
        read_check(t, idx);
    endtask

    // Trap and return port, a waiting return goes on the first trap-free cycle
    task automatic run_events(input logic trap_en, input logic eret_en, input int tthread,
        input int ethread, input int reason, input scalar_t pc, input scalar_t addr, input int sub);
        logic trap_pending;
        logic eret_pending;
        trap_pending = trap_en;
        eret_pending = eret_en;
        @(posedge clk);
        trap_valid <= trap_en;
        trap_reason <= trap_reason_t'(4'(reason));
        trap_pc <= pc;
        trap_access_addr <= addr;
        trap_thread <= 2'(tthread);
        trap_subcycle <= 4'(sub);
        eret_valid <= eret_en;
        eret_thread <= 2'(ethread);
        while (trap_pending || eret_pending)
        begin
            @(negedge clk);
            if (trap_pending)
            begin
                if (eret_pending)
                    check_value("eret_ready", scalar_t'(eret_ready), '0);
                model_trap(tthread, reason, pc, addr, sub);
                trap_pending = 1'b0;
            end
            else
            begin
                check_value("eret_ready", scalar_t'(eret_ready), 32'h1);
                model_eret(ethread);
                eret_pending = 1'b0;
            end
            @(posedge clk);
            trap_valid <= 1'b0;
            eret_valid <= eret_pending;
        end
        // Sequencer stage plus register update
        @(posedge clk);
        @(negedge clk);
        check_outputs();
    endtask

    initial
    begin
        repeat ((RANDOM_OPS * 13 + DIRECTED_TRANSFERS) * 10 + 200)
            @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial
    begin
        int op;
        int t;
        int idx;
        int other;
        int reason;
        int sub;
        logic upper;
        scalar_t data;
        scalar_t pc;
        scalar_t addr;
        scalar_t first;
        scalar_t second;
        logic err;

        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= '0;
        pwdata <= '0;
        trap_valid <= 1'b0;
        trap_reason <= TR_RESET;
        trap_pc <= '0;
        trap_access_addr <= '0;
        trap_thread <= '0;
        trap_subcycle <= '0;
        eret_valid <= 1'b0;
        eret_thread <= '0;
        lfsr_state = 32'h3c359a16;
        model_reset();

        @(negedge reset);
        @(negedge clk);
        check_outputs();
        for (int i = 0; i < NUM_THREADS; i++)
            read_thread_all(i);

        for (int n = 0; n < RANDOM_OPS; n++)
        begin
            op = int'(take_bits(3));
            t = int'(take_bits(2));
            idx = int'(take_bits(4));
            other = int'(take_bits(2));
            reason = int'(take_bits(4) % 9);
            sub = int'(take_bits(4));
            upper = take_bits(1) == 1;
            data = take_bits(32);
            pc = take_bits(32);
            addr = take_bits(32);
            case (op)
                0, 1:
                begin
                    reg_write(t, idx, data);
                    read_check(t, idx);
                end
                2, 3:
                    read_check(t, idx);
                4:
                begin
                    run_events(1'b1, 1'b0, t, 0, reason, pc, addr, sub);
                    read_thread_all(t);
                end
                5:
                    run_events(1'b0, 1'b1, 0, t, 0, '0, '0, 0);
                6:
                begin
                    run_events(1'b1, 1'b1, t, other, reason, pc, addr, sub);
                    read_thread_all(other);
                end
                default:
                    bad_access(data[0], t, idx, data, upper);
            endcase
        end

        // Two nested traps on thread 2, unwound one level at a time
        reg_write(2, CR_FLAGS, 32'h3);
        reg_write(2, CR_SCRATCHPAD0, 32'h1111_0000);
        reg_write(2, CR_SCRATCHPAD1, 32'h2222_0000);
        run_events(1'b1, 1'b0, 2, 0, TR_SYSCALL, 32'h0000_4000, 32'h0000_0040, 3);
        read_thread_all(2);
        reg_write(2, CR_FLAGS, 32'h7);
        reg_write(2, CR_SCRATCHPAD0, 32'h1111_0001);
        run_events(1'b1, 1'b0, 2, 0, TR_DTLB_MISS, 32'h0000_5000, 32'h0080_0000, 7);
        read_thread_all(2);
        // Level 0 differs from level 1 before each return
        reg_write(2, CR_SCRATCHPAD0, 32'h1111_0002);
        run_events(1'b0, 1'b1, 0, 2, 0, '0, '0, 0);
        read_thread_all(2);
        reg_write(2, CR_SCRATCHPAD1, 32'h2222_0003);
        run_events(1'b0, 1'b1, 0, 2, 0, '0, '0, 0);
        for (int i = 0; i < NUM_THREADS; i++)
            read_thread_all(i);

        // Return presented together with a trap on the same thread
        reg_write(1, CR_FLAGS, 32'h2);
        run_events(1'b1, 1'b1, 1, 1, TR_ITLB_MISS, 32'h0000_6000, 32'h0000_1234, 5);
        read_thread_all(1);

        apb_transfer(1'b0, reg_addr(0, CR_CYCLE_COUNT), '0, first, err);
        apb_transfer(1'b0, reg_addr(0, CR_CYCLE_COUNT), '0, second, err);
        assert (second - first >= 2)
        else
        begin
            $display("Fail cycle_count expected at least %h got %h", first + 2, second);
            $display("TESTS FAILED");
            $fatal(1);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* verif/tb_clock.sv */
// Testbench clock and reset source

`timescale 1ns/10ps

module tb_clock
    #(parameter PERIOD = 20,
    parameter RESET_CYCLES = 3)
    (output logic clk,
    output logic reset);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD / 2) clk = ~clk;
    end

    // Reset held over the first rising edges
    initial
    begin
        reset <= 1'b1;
        repeat (RESET_CYCLES)
            @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* verilog/creg_subsystem.sv */
// Control register subsystem top level
// APB bridge and trap sequencer feeding the register file

`timescale 1ns/10ps

module creg_subsystem
    import creg_pkg::*;
    #(parameter NUM_THREADS = 4,
    parameter CORE_ID = 0,
    localparam THREAD_IDX_WIDTH = $clog2(NUM_THREADS))
    (input                                  clk,
    input                                   reset,

    // APB slave port
    input                                   psel,
    input                                   penable,
    input                                   pwrite,
    input [11:0]                            paddr,
    input scalar_t                          pwdata,
    output scalar_t                         prdata,
    output logic                            pready,
    output logic                            pslverr,

    // Trap and return port
    input                                   trap_valid,
    input trap_reason_t                     trap_reason,
    input scalar_t                          trap_pc,
    input scalar_t                          trap_access_addr,
    input [THREAD_IDX_WIDTH - 1:0]          trap_thread,
    input subcycle_t                        trap_subcycle,
    input                                   eret_valid,
    input [THREAD_IDX_WIDTH - 1:0]          eret_thread,
    output logic                            eret_ready,

    // Current state
    output logic [NUM_THREADS - 1:0]        mmu_en,
    output logic [NUM_THREADS - 1:0]        supervisor_en,
    output logic [NUM_THREADS - 1:0]        interrupt_en,
    output logic [ASID_WIDTH - 1:0]         current_asid[NUM_THREADS],
    output scalar_t                         eret_address[NUM_THREADS],
    output scalar_t                         trap_handler,
    output scalar_t                         tlb_miss_handler);

    // Bridge to register file
    logic creg_write_en;
    logic creg_read_en;
    logic [THREAD_IDX_WIDTH - 1:0] creg_thread;
    control_register_t creg_index;
    scalar_t creg_write_val;
    scalar_t creg_read_val;

    // Sequencer to register file
    logic seq_trap;
    trap_reason_t seq_trap_reason;
    scalar_t seq_trap_pc;
    scalar_t seq_trap_access_addr;
    logic [THREAD_IDX_WIDTH - 1:0] seq_trap_thread;
    subcycle_t seq_trap_subcycle;
    logic seq_eret;
    logic [THREAD_IDX_WIDTH - 1:0] seq_eret_thread;

    apb_creg_bridge #(.NUM_THREADS(NUM_THREADS)) apb_creg_bridge(.*);

    trap_sequencer #(.NUM_THREADS(NUM_THREADS)) trap_sequencer(.*);

    control_registers #(
        .NUM_THREADS(NUM_THREADS),
        .CORE_ID(CORE_ID)
    ) control_registers(.*);

endmodule

/* verilog/control_registers.sv */
// Per-thread flags, ASID, two-level trap state and scratchpads
// Global handler addresses, cycle counter and registered read port

`timescale 1ns/10ps

module control_registers
    import creg_pkg::*;
    #(parameter NUM_THREADS = 4,
    parameter CORE_ID = 0,
    localparam THREAD_IDX_WIDTH = $clog2(NUM_THREADS))
    (input                                  clk,
    input                                   reset,

    // From APB bridge
    input                                   creg_write_en,
    input                                   creg_read_en,
    input [THREAD_IDX_WIDTH - 1:0]          creg_thread,
    input control_register_t                creg_index,
    input scalar_t                          creg_write_val,
    output scalar_t                         creg_read_val,

    // From trap sequencer
    input                                   seq_trap,
    input trap_reason_t                     seq_trap_reason,
    input scalar_t                          seq_trap_pc,
    input scalar_t                          seq_trap_access_addr,
    input [THREAD_IDX_WIDTH - 1:0]          seq_trap_thread,
    input subcycle_t                        seq_trap_subcycle,
    input                                   seq_eret,
    input [THREAD_IDX_WIDTH - 1:0]          seq_eret_thread,

    // Current state
    output logic [NUM_THREADS - 1:0]        mmu_en,
    output logic [NUM_THREADS - 1:0]        supervisor_en,
    output logic [NUM_THREADS - 1:0]        interrupt_en,
    output logic [ASID_WIDTH - 1:0]         current_asid[NUM_THREADS],
    output scalar_t                         eret_address[NUM_THREADS],
    output scalar_t                         trap_handler,
    output scalar_t                         tlb_miss_handler);

    // Level 0 is the active trap, level 1 the one it interrupted
    logic [NUM_THREADS - 1:0] supervisor_saved[2];
    logic [NUM_THREADS - 1:0] mmu_saved[2];
    logic [NUM_THREADS - 1:0] interrupt_saved[2];
    trap_reason_t reason_saved[2][NUM_THREADS];
    scalar_t trap_pc_saved[2][NUM_THREADS];
    scalar_t access_addr_saved[2][NUM_THREADS];
    subcycle_t subcycle_saved[2][NUM_THREADS];
    scalar_t scratchpad[2][NUM_THREADS][2];
    scalar_t cycle_count;

    assign eret_address = trap_pc_saved[0];

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int lvl = 0; lvl < 2; lvl++)
            begin
                supervisor_saved[lvl] <= '0;
                mmu_saved[lvl] <= '0;
                interrupt_saved[lvl] <= '0;
                for (int t = 0; t < NUM_THREADS; t++)
                begin
                    reason_saved[lvl][t] <= TR_RESET;
                    trap_pc_saved[lvl][t] <= '0;
                    access_addr_saved[lvl][t] <= '0;
                    subcycle_saved[lvl][t] <= '0;
                    scratchpad[lvl][t][0] <= '0;
                    scratchpad[lvl][t][1] <= '0;
                end
            end

            for (int t = 0; t < NUM_THREADS; t++)
                current_asid[t] <= '0;

            // Threads come up in supervisor mode
            supervisor_en <= '1;
            mmu_en <= '0;
            interrupt_en <= '0;
            trap_handler <= '0;
            tlb_miss_handler <= '0;
            cycle_count <= '0;
        end
        else
        begin
            cycle_count <= cycle_count + 1;

            if (seq_trap)
            begin
                // Push level 0 of the trapping thread down
                supervisor_saved[1][seq_trap_thread] <= supervisor_saved[0][seq_trap_thread];
                mmu_saved[1][seq_trap_thread] <= mmu_saved[0][seq_trap_thread];
                interrupt_saved[1][seq_trap_thread] <= interrupt_saved[0][seq_trap_thread];
                reason_saved[1][seq_trap_thread] <= reason_saved[0][seq_trap_thread];
                trap_pc_saved[1][seq_trap_thread] <= trap_pc_saved[0][seq_trap_thread];
                access_addr_saved[1][seq_trap_thread] <= access_addr_saved[0][seq_trap_thread];
                subcycle_saved[1][seq_trap_thread] <= subcycle_saved[0][seq_trap_thread];
                scratchpad[1][seq_trap_thread] <= scratchpad[0][seq_trap_thread];

                // Save current flags and record the trap
                supervisor_saved[0][seq_trap_thread] <= supervisor_en[seq_trap_thread];
                mmu_saved[0][seq_trap_thread] <= mmu_en[seq_trap_thread];
                interrupt_saved[0][seq_trap_thread] <= interrupt_en[seq_trap_thread];
                reason_saved[0][seq_trap_thread] <= seq_trap_reason;
                trap_pc_saved[0][seq_trap_thread] <= seq_trap_pc;
                access_addr_saved[0][seq_trap_thread] <= seq_trap_access_addr;
                subcycle_saved[0][seq_trap_thread] <= seq_trap_subcycle;

                interrupt_en[seq_trap_thread] <= 1'b0;
                supervisor_en[seq_trap_thread] <= 1'b1;
                if (seq_trap_reason == TR_ITLB_MISS || seq_trap_reason == TR_DTLB_MISS)
                    mmu_en[seq_trap_thread] <= 1'b0;
            end
            else if (seq_eret)
            begin
                supervisor_en[seq_eret_thread] <= supervisor_saved[0][seq_eret_thread];
                mmu_en[seq_eret_thread] <= mmu_saved[0][seq_eret_thread];
                interrupt_en[seq_eret_thread] <= interrupt_saved[0][seq_eret_thread];

                // Pop the nested level back up
                supervisor_saved[0][seq_eret_thread] <= supervisor_saved[1][seq_eret_thread];
                mmu_saved[0][seq_eret_thread] <= mmu_saved[1][seq_eret_thread];
                interrupt_saved[0][seq_eret_thread] <= interrupt_saved[1][seq_eret_thread];
                reason_saved[0][seq_eret_thread] <= reason_saved[1][seq_eret_thread];
                trap_pc_saved[0][seq_eret_thread] <= trap_pc_saved[1][seq_eret_thread];
                access_addr_saved[0][seq_eret_thread] <= access_addr_saved[1][seq_eret_thread];
                subcycle_saved[0][seq_eret_thread] <= subcycle_saved[1][seq_eret_thread];
                scratchpad[0][seq_eret_thread] <= scratchpad[1][seq_eret_thread];
            end

            // Register writes come last so they override a trap on the same edge
            if (creg_write_en)
            begin
                case (creg_index)
                    CR_FLAGS:
                    begin
                        supervisor_en[creg_thread] <= creg_write_val[2];
                        mmu_en[creg_thread] <= creg_write_val[1];
                        interrupt_en[creg_thread] <= creg_write_val[0];
                    end

                    CR_SAVED_FLAGS:
                    begin
                        supervisor_saved[0][creg_thread] <= creg_write_val[2];
                        mmu_saved[0][creg_thread] <= creg_write_val[1];
                        interrupt_saved[0][creg_thread] <= creg_write_val[0];
                    end

                    CR_TRAP_PC:          trap_pc_saved[0][creg_thread] <= creg_write_val;
                    CR_TRAP_HANDLER:     trap_handler <= creg_write_val;
                    CR_TLB_MISS_HANDLER: tlb_miss_handler <= creg_write_val;
                    CR_SCRATCHPAD0:      scratchpad[0][creg_thread][0] <= creg_write_val;
                    CR_SCRATCHPAD1:      scratchpad[0][creg_thread][1] <= creg_write_val;
                    CR_SUBCYCLE:
                        subcycle_saved[0][creg_thread] <= creg_write_val[SUBCYCLE_WIDTH - 1:0];
                    CR_CURRENT_ASID:
                        current_asid[creg_thread] <= creg_write_val[ASID_WIDTH - 1:0];
                    default:
                        ;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (creg_read_en)
        begin
            case (creg_index)
                CR_FLAGS:
                    creg_read_val <= scalar_t'({supervisor_en[creg_thread],
                        mmu_en[creg_thread], interrupt_en[creg_thread]});
                CR_SAVED_FLAGS:
                    creg_read_val <= scalar_t'({supervisor_saved[0][creg_thread],
                        mmu_saved[0][creg_thread], interrupt_saved[0][creg_thread]});
                CR_THREAD_ID:
                    creg_read_val <= scalar_t'(CORE_ID * NUM_THREADS) + scalar_t'(creg_thread);
                CR_TRAP_PC:          creg_read_val <= trap_pc_saved[0][creg_thread];
                CR_TRAP_REASON:      creg_read_val <= scalar_t'(reason_saved[0][creg_thread]);
                CR_TRAP_HANDLER:     creg_read_val <= trap_handler;
                CR_TRAP_ADDRESS:     creg_read_val <= access_addr_saved[0][creg_thread];
                CR_TLB_MISS_HANDLER: creg_read_val <= tlb_miss_handler;
                CR_CYCLE_COUNT:      creg_read_val <= cycle_count;
                CR_SCRATCHPAD0:      creg_read_val <= scratchpad[0][creg_thread][0];
                CR_SCRATCHPAD1:      creg_read_val <= scratchpad[0][creg_thread][1];
                CR_SUBCYCLE:         creg_read_val <= scalar_t'(subcycle_saved[0][creg_thread]);
                CR_CURRENT_ASID:     creg_read_val <= scalar_t'(current_asid[creg_thread]);
                default:             creg_read_val <= 32'hffffffff;
            endcase
        end
    end

    // Bridge issues one strobe per transfer
    read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(creg_write_en && creg_read_en));

endmodule

/* verilog/trap_sequencer.sv */
// Trap and return sequencer, one register stage ahead of the register file
// Traps win over returns, which wait on eret_ready

`timescale 1ns/10ps

module trap_sequencer
    import creg_pkg::*;
    #(parameter NUM_THREADS = 4,
    localparam THREAD_IDX_WIDTH = $clog2(NUM_THREADS))
    (input                                  clk,
    input                                   reset,

    // Trap and return port
    input                                   trap_valid,
    input trap_reason_t                     trap_reason,
    input scalar_t                          trap_pc,
    input scalar_t                          trap_access_addr,
    input [THREAD_IDX_WIDTH - 1:0]          trap_thread,
    input subcycle_t                        trap_subcycle,
    input                                   eret_valid,
    input [THREAD_IDX_WIDTH - 1:0]          eret_thread,
    output logic                            eret_ready,

    // To register file
    output logic                            seq_trap,
    output trap_reason_t                    seq_trap_reason,
    output scalar_t                         seq_trap_pc,
    output scalar_t                         seq_trap_access_addr,
    output logic [THREAD_IDX_WIDTH - 1:0]   seq_trap_thread,
    output subcycle_t                       seq_trap_subcycle,
    output logic                            seq_eret,
    output logic [THREAD_IDX_WIDTH - 1:0]   seq_eret_thread);

    // A trap in this cycle holds off any return
    assign eret_ready = !trap_valid;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            seq_trap <= 1'b0;
            seq_eret <= 1'b0;
        end
        else
        begin
            seq_trap <= trap_valid;
            seq_eret <= eret_valid && eret_ready;
        end
    end

    // Event payload
    always_ff @(posedge clk)
    begin
        if (trap_valid)
        begin
            seq_trap_reason <= trap_reason;
            seq_trap_pc <= trap_pc;
            seq_trap_access_addr <= trap_access_addr;
            seq_trap_thread <= trap_thread;
            seq_trap_subcycle <= trap_subcycle;
        end

        if (eret_valid && eret_ready)
            seq_eret_thread <= eret_thread;
    end

    seq_events_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(seq_trap && seq_eret));

    // A held-off return stays put until it is taken
    eret_held_stable: assert property (@(posedge clk) disable iff (reset)
        eret_valid && !eret_ready |=> eret_valid && $stable(eret_thread));

endmodule

/* verilog/apb_creg_bridge.sv */
// APB slave front end for the control registers
// Address decode, access strobes and one wait state per transfer

`timescale 1ns/10ps

module apb_creg_bridge
    import creg_pkg::*;
    #(parameter NUM_THREADS = 4,
    localparam THREAD_IDX_WIDTH = $clog2(NUM_THREADS))
    (input                                  clk,
    input                                   reset,

    // APB slave port
    input                                   psel,
    input                                   penable,
    input                                   pwrite,
    input [11:0]                            paddr,
    input scalar_t                          pwdata,
    output scalar_t                         prdata,
    output logic                            pready,
    output logic                            pslverr,

    // Register file access
    output logic                            creg_write_en,
    output logic                            creg_read_en,
    output logic [THREAD_IDX_WIDTH - 1:0]   creg_thread,
    output control_register_t               creg_index,
    output scalar_t                         creg_write_val,
    input scalar_t                          creg_read_val);

    // First bit above the thread index, must read as zero
    localparam UPPER_LSB = THREAD_INDEX_LSB + THREAD_IDX_WIDTH;

    logic access_first;
    logic addr_bad;

    // First access cycle, pready is still low there
    assign access_first = psel && penable && !pready;

    assign addr_bad = (paddr[1:0] != 2'b00) || (paddr[11:UPPER_LSB] != '0);

    // One strobe per transfer, none for a bad address
    assign creg_write_en = access_first && pwrite && !addr_bad;
    assign creg_read_en = access_first && !pwrite && !addr_bad;

    assign creg_thread = paddr[THREAD_INDEX_LSB +: THREAD_IDX_WIDTH];
    assign creg_index = control_register_t'(paddr[REG_INDEX_LSB +: $bits(control_register_t)]);
    assign creg_write_val = pwdata;

    // Register file holds the read value captured at the strobe
    assign prdata = pslverr ? '0 : creg_read_val;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            pready <= 1'b0;
            pslverr <= 1'b0;
        end
        else
        begin
            pready <= access_first;
            pslverr <= access_first && addr_bad;
        end
    end

    // Host must hold psel through the access phase
    penable_needs_psel: assert property (@(posedge clk) disable iff (reset)
        penable |-> psel);

endmodule

/* verilog/creg_pkg.sv */
// Shared types and widths for the control register subsystem
// Data word, register indexes, trap reasons and address field positions

package creg_pkg;

    typedef logic [31:0] scalar_t;

    localparam ASID_WIDTH = 8;
    localparam SUBCYCLE_WIDTH = 4;

    // Address layout of an APB register access
    localparam REG_INDEX_LSB = 2;
    localparam THREAD_INDEX_LSB = 7;

    typedef logic [SUBCYCLE_WIDTH - 1:0] subcycle_t;

    typedef enum logic [4:0] {
        CR_FLAGS            = 5'd0,
        CR_SAVED_FLAGS      = 5'd1,
        CR_THREAD_ID        = 5'd2,
        CR_TRAP_PC          = 5'd3,
        CR_TRAP_REASON      = 5'd4,
        CR_TRAP_HANDLER     = 5'd5,
        CR_TRAP_ADDRESS     = 5'd6,
        CR_TLB_MISS_HANDLER = 5'd7,
        CR_CYCLE_COUNT      = 5'd8,
        CR_SCRATCHPAD0      = 5'd9,
        CR_SCRATCHPAD1      = 5'd10,
        CR_SUBCYCLE         = 5'd11,
        CR_CURRENT_ASID     = 5'd12
    } control_register_t;

    typedef enum logic [3:0] {
        TR_RESET,
        TR_ILLEGAL_INSTRUCTION,
        TR_PRIVILEGED_OP,
        TR_INTERRUPT,
        TR_SYSCALL,
        TR_UNALIGNED_ACCESS,
        TR_PAGE_FAULT,
        TR_ITLB_MISS,
        TR_DTLB_MISS
    } trap_reason_t;

endpackage
